/* sd_cfg.svh */
`ifndef SD_CFG_SVH
`define SD_CFG_SVH

// Number of z2 samples gathered into one word by the collector.
// The oldest sample ends up in the most significant bit
`define SD_WORD_BITS 16

// Clocks in one timing frame, one per phase strobe.
// The phase order is v1, w2, x1, y7, z2
`define SD_FRAME_PHASES 5

// The sampler takes one sample per frame, so the word period in clocks
// is the product of the two values above

`endif

/* sd_pkg.sv */
`include "sd_cfg.svh"

package sd_pkg;

    // One-hot timing phase strobes, exactly one bit high per clock
    typedef struct packed {
        logic v1;
        logic w2;
        logic x1;
        logic y7;
        logic z2;
    } sd_phase_t;

    // Discrete inputs that feed the ml1_2 sampling network
    typedef struct packed {
        logic c4rdn;
        logic cr1;
        logic cr2;
        logic crcav;
        logic diad;
        logic din11;
        logic din12;
        logic g1dvn;
        logic g7dvn;
        logic gc1;
        logic gc2;
        logic icsd;
        logic icsdn;
        logic mlav;
        logic paav;
        logic pbg2v;
        logic pcg2v;
        logic resmv;
        logic ssa;
        logic ssfb2;
        logic ssfb3;
    } sd_discretes_t;

    // One collected word, oldest sample in the MSB
    typedef logic [`SD_WORD_BITS-1:0] sd_word_t;

endpackage

/* sd_gates.sv */
`timescale 1ns/1ps

// Discrete input buffer with one clock of delay, output is the inverted input
module dia (
    output logic y,
    input  logic a,
    input  logic sim_clk,
    input  logic rst
);

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            y <= 1'b1;
        end else begin
            y <= ~a;
        end
    end

endmodule

// Inverter cell, combinational when delay is 0 and registered otherwise
module inv #(
    parameter int delay = 1
) (
    output logic y,
    input  logic a,
    input  logic sim_clk,
    input  logic rst
);

    generate
        if (delay == 0) begin : g_comb
            assign y = ~a;
        end else begin : g_reg
            always_ff @(posedge sim_clk) begin
                if (rst) begin
                    y <= 1'b1;
                end else begin
                    y <= ~a;
                end
            end
        end
    endgenerate

endmodule

/* sd_phase_gen.sv */
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sd_phase_gen (
    input  logic              sim_clk,
    input  logic              rst,
    output sd_pkg::sd_phase_t phase
);

    localparam int PHASES = `SD_FRAME_PHASES;
    localparam int CNT_W  = $clog2(PHASES);

    // Position in the current frame, 0 is v1
    logic [CNT_W-1:0] count_q;
    logic             frame_end;

    assign frame_end = (count_q == CNT_W'(PHASES - 1));

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (frame_end) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // The count is held at zero through reset, so v1 is already showing
    // in the first clock after release
    always_comb begin
        phase = '0;
        case (count_q)
            CNT_W'(0): begin
                phase.v1 = 1'b1;
            end
            CNT_W'(1): begin
                phase.w2 = 1'b1;
            end
            CNT_W'(2): begin
                phase.x1 = 1'b1;
            end
            CNT_W'(3): begin
                phase.y7 = 1'b1;
            end
            CNT_W'(4): begin
                phase.z2 = 1'b1;
            end
            default: begin
                phase.v1 = 1'b1;
            end
        endcase
    end

endmodule

/* sd_sampler_2.sv */
`timescale 1ns/1ps

module sd_sampler_2 (
    input  logic                  sim_clk,
    input  logic                  rst,
    input  sd_pkg::sd_phase_t     phase,
    input  sd_pkg::sd_discretes_t discretes,
    output logic                  ml1_2
);

    // Registered inverses of the buffered discretes
    logic cr1n;
    logic cr2n;
    logic gc1n;
    logic gc2n;
    logic din11n;
    logic din12n;
    logic ssfb2n;
    logic ssfb3n;

    logic ml1_2n;

    // Gated set products, one per phase condition
    logic set_y7_cr1;
    logic set_y7_c4;
    logic set_x1_cr2;
    logic set_z2_gc1;
    logic set_z2_ssfb;
    logic set_w2_gc2;
    logic set_z2_din;
    logic set_w2_din;
    logic set_x1_ssfb;
    logic set_v1_hold;
    logic set_term;

    logic hold_term;

    dia u_dia_cr1   (.y(cr1n),   .a(discretes.cr1),   .sim_clk(sim_clk), .rst(rst));
    dia u_dia_cr2   (.y(cr2n),   .a(discretes.cr2),   .sim_clk(sim_clk), .rst(rst));
    dia u_dia_gc1   (.y(gc1n),   .a(discretes.gc1),   .sim_clk(sim_clk), .rst(rst));
    dia u_dia_gc2   (.y(gc2n),   .a(discretes.gc2),   .sim_clk(sim_clk), .rst(rst));
    dia u_dia_din11 (.y(din11n), .a(discretes.din11), .sim_clk(sim_clk), .rst(rst));
    dia u_dia_din12 (.y(din12n), .a(discretes.din12), .sim_clk(sim_clk), .rst(rst));
    dia u_dia_ssfb2 (.y(ssfb2n), .a(discretes.ssfb2), .sim_clk(sim_clk), .rst(rst));
    dia u_dia_ssfb3 (.y(ssfb3n), .a(discretes.ssfb3), .sim_clk(sim_clk), .rst(rst));

    assign set_y7_cr1 = phase.y7 & ~cr1n & discretes.icsd
                      & discretes.pbg2v & discretes.crcav;

    assign set_y7_c4 = phase.y7 & ~discretes.c4rdn & discretes.paav
                     & discretes.g1dvn & discretes.g7dvn;

    assign set_x1_cr2 = phase.x1 & ~cr2n & discretes.icsd
                      & discretes.pcg2v & discretes.crcav;

    assign set_z2_gc1 = phase.z2 & ~gc1n & discretes.icsdn
                      & discretes.crcav & discretes.pbg2v;

    assign set_z2_ssfb = phase.z2 & ssfb2n & discretes.ssa & discretes.pbg2v;

    assign set_w2_gc2 = phase.w2 & ~gc2n & discretes.crcav
                      & discretes.pcg2v & discretes.icsdn;

    assign set_z2_din = phase.z2 & din11n & discretes.pbg2v & discretes.diad;

    assign set_w2_din = phase.w2 & din12n & discretes.pcg2v & discretes.diad;

    assign set_x1_ssfb = phase.x1 & discretes.pcg2v & ssfb3n & discretes.ssa;

    // Feedback from the registered complement keeps the line set at v1
    assign set_v1_hold = phase.v1 & ml1_2n;

    assign set_term = set_y7_cr1 | set_y7_c4 | set_x1_cr2 | set_z2_gc1
                    | set_z2_ssfb | set_w2_gc2 | set_z2_din | set_w2_din
                    | set_x1_ssfb | set_v1_hold;

    // z2 with resmv and mlav together releases the hold
    assign hold_term = (phase.v1 & ml1_2)
                     | (phase.z2 & discretes.resmv & discretes.mlav);

    inv #(.delay(0)) u_inv_ml1_2 (
        .y       (ml1_2),
        .a       (set_term),
        .sim_clk (sim_clk),
        .rst     (rst)
    );

    inv #(.delay(1)) u_inv_ml1_2n (
        .y       (ml1_2n),
        .a       (hold_term),
        .sim_clk (sim_clk),
        .rst     (rst)
    );

endmodule

/* sd_word_collector.sv */
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sd_word_collector (
    input  logic              sim_clk,
    input  logic              rst,
    input  sd_pkg::sd_phase_t phase,
    input  logic              ml1_2,
    output sd_pkg::sd_word_t  word,
    output logic              word_valid
);

    import sd_pkg::*;

    localparam int WORD_BITS = `SD_WORD_BITS;
    localparam int CNT_W     = $clog2(WORD_BITS + 1);

    sd_word_t         shift_q;
    logic [CNT_W-1:0] count_q;
    logic             last_sample;

    // The z2 sample that fills the word
    assign last_sample = phase.z2 && (count_q == CNT_W'(WORD_BITS - 1));

    // New samples enter at the LSB so the oldest one drifts to the MSB
    always_ff @(posedge sim_clk) begin
        if (phase.z2) begin
            shift_q <= (shift_q << 1) | sd_word_t'(ml1_2);
        end
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (last_sample) begin
            count_q <= '0;
        end else if (phase.z2) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Strobe lands in the clock after the last z2, when the word is complete.
    // No shift happens in that clock since it is always a v1 cycle
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= last_sample;
        end
    end

    assign word = shift_q;

endmodule

/* sd_top.sv */
`timescale 1ns/1ps

module sd_top (
    input  logic                  sim_clk,
    input  logic                  rst,
    input  sd_pkg::sd_discretes_t discretes,
    output sd_pkg::sd_word_t      word,
    output logic                  word_valid
);

    import sd_pkg::*;

    sd_phase_t phase;
    logic      ml1_2;

    sd_phase_gen u_phase_gen (
        .sim_clk (sim_clk),
        .rst     (rst),
        .phase   (phase)
    );

    sd_sampler_2 u_sampler (
        .sim_clk   (sim_clk),
        .rst       (rst),
        .phase     (phase),
        .discretes (discretes),
        .ml1_2     (ml1_2)
    );

    // One sample of ml1_2 per frame, taken at z2
    sd_word_collector u_collector (
        .sim_clk    (sim_clk),
        .rst        (rst),
        .phase      (phase),
        .ml1_2      (ml1_2),
        .word       (word),
        .word_valid (word_valid)
    );

endmodule

/* sd_top_assert.sv */
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sd_top_assert (
    input logic              sim_clk,
    input logic              rst,
    input sd_pkg::sd_phase_t phase,
    input logic              word_valid
);

    localparam int STROBE_PERIOD = `SD_FRAME_PHASES * `SD_WORD_BITS;

    int unsigned assert_errors = 0;

    // Clocks since the last strobe, or since reset for the first one
    logic [31:0] gap_q;

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            gap_q <= '0;
        end else if (word_valid) begin
            gap_q <= 32'd1;
        end else begin
            gap_q <= gap_q + 32'd1;
        end
    end

    // Each phase hands over to the next one, and v1 comes first after reset
    phase_onehot: assert property (@(posedge sim_clk) disable iff (rst)
        $onehot(phase) && (phase == ($past(rst) ? 5'b10000
                                                : {$past(phase.z2), $past(phase.v1),
                                                   $past(phase.w2), $past(phase.x1),
                                                   $past(phase.y7)})))
        else begin
            assert_errors++;
            $error("phase strobes are not one-hot or out of order: %b", phase);
        end

    strobe_single: assert property (@(posedge sim_clk) disable iff (rst)
        word_valid |=> !word_valid)
        else begin
            assert_errors++;
            $error("word_valid stayed high for two cycles");
        end

    strobe_spacing: assert property (@(posedge sim_clk) disable iff (rst)
        word_valid |-> gap_q == STROBE_PERIOD)
        else begin
            assert_errors++;
            $error("word_valid came %0d clocks after the previous one", gap_q);
        end

endmodule

bind sd_top sd_top_assert u_assert (
    .sim_clk    (sim_clk),
    .rst        (rst),
    .phase      (phase),
    .word_valid (word_valid)
);

/* tb_sd_top.sv */
`timescale 1ns/1ps
`include "sd_cfg.svh"

module tb_sd_top;

    import sd_pkg::*;

    localparam int PHASES      = `SD_FRAME_PHASES;
    localparam int WORD_BITS   = `SD_WORD_BITS;
    localparam int WORD_CYCLES = PHASES * WORD_BITS;
    localparam int TOTAL_WORDS = 230;
    localparam int MAX_CYCLES  = (TOTAL_WORDS * WORD_CYCLES + 10) * 3 / 2;

    logic          sim_clk;
    logic          rst;
    sd_discretes_t discretes;
    sd_word_t      word;
    logic          word_valid;

    logic [31:0] lfsr_state;
    string       cur_test;
    int          cycle_count = 0;

    // Reference model state, mirrors the card one clock at a time
    int          ref_phase;
    logic [7:0]  ref_inv;
    logic        ref_mln;
    int          ref_count;
    sd_word_t    ref_shift;
    logic [1:0]  ref_out;
    int          run_cycles;
    int          words_checked = 0;
    sd_word_t    exp_q[$];
    string       name_q[$];

    sd_top DUT (
        .sim_clk    (sim_clk),
        .rst        (rst),
        .discretes  (discretes),
        .word       (word),
        .word_valid (word_valid)
    );

    initial begin
        sim_clk = 1'b0;
        forever #5 sim_clk = ~sim_clk;
    end

    task automatic end_in_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            end_in_failure();
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic next_random(output sd_discretes_t d);
        logic [$bits(sd_discretes_t)-1:0] bits;
        for (int i = 0; i < $bits(sd_discretes_t); i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits[i] = lfsr_state[0];
        end
        d = sd_discretes_t'(bits);
    endtask

    // Order is cr1, cr2, gc1, gc2, din11, din12, ssfb2, ssfb3
    function automatic logic [7:0] inverted_inputs(input sd_discretes_t d);
        return ~{d.cr1, d.cr2, d.gc1, d.gc2, d.din11, d.din12, d.ssfb2, d.ssfb3};
    endfunction

    // Returns the line for this cycle and the next value of its registered complement
    function automatic logic [1:0] ref_cycle(input int ph, input sd_discretes_t d,
                                             input logic [7:0] q, input logic mln);
        logic v1, w2, x1, y7, z2;
        logic s;
        logic ml;
        v1 = (ph == 0);
        w2 = (ph == 1);
        x1 = (ph == 2);
        y7 = (ph == 3);
        z2 = (ph == 4);
        s = (y7 & ~q[7] & d.icsd & d.pbg2v & d.crcav)
          | (y7 & ~d.c4rdn & d.paav & d.g1dvn & d.g7dvn)
          | (x1 & ~q[6] & d.icsd & d.pcg2v & d.crcav)
          | (z2 & ~q[5] & d.icsdn & d.crcav & d.pbg2v)
          | (z2 & q[1] & d.ssa & d.pbg2v)
          | (w2 & ~q[4] & d.crcav & d.pcg2v & d.icsdn)
          | (z2 & q[3] & d.pbg2v & d.diad)
          | (w2 & q[2] & d.pcg2v & d.diad)
          | (x1 & d.pcg2v & q[0] & d.ssa)
          | (v1 & mln);
        ml = ~s;
        return {ml, ~((v1 & ml) | (z2 & d.resmv & d.mlav))};
    endfunction

    // Inputs that make one product term true, numbered in rule order
    function automatic sd_discretes_t term_inputs(input int k);
        case (k)
            0: return '{cr1: 1'b1, icsd: 1'b1, pbg2v: 1'b1, crcav: 1'b1, default: 1'b0};
            1: return '{paav: 1'b1, g1dvn: 1'b1, g7dvn: 1'b1, default: 1'b0};
            2: return '{cr2: 1'b1, icsd: 1'b1, pcg2v: 1'b1, crcav: 1'b1, default: 1'b0};
            3: return '{gc1: 1'b1, icsdn: 1'b1, crcav: 1'b1, pbg2v: 1'b1, default: 1'b0};
            4: return '{ssa: 1'b1, pbg2v: 1'b1, default: 1'b0};
            5: return '{gc2: 1'b1, crcav: 1'b1, pcg2v: 1'b1, icsdn: 1'b1, default: 1'b0};
            6: return '{pbg2v: 1'b1, diad: 1'b1, default: 1'b0};
            7: return '{pcg2v: 1'b1, diad: 1'b1, default: 1'b0};
            default: return '{pcg2v: 1'b1, ssa: 1'b1, default: 1'b0};
        endcase
    endfunction

    task automatic wait_strobes(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge sim_clk);
            while (!word_valid) @(posedge sim_clk);
        end
    endtask

    task automatic soak(input int words);
        sd_discretes_t d;
        int            seen;
        seen = 0;
        while (seen < words) begin
            next_random(d);
            discretes <= d;
            @(posedge sim_clk);
            if (word_valid) seen++;
        end
    endtask

    // Compare first, then advance the model past the cycle that just ended
    always @(posedge sim_clk) begin
        if (rst) begin
            ref_phase  = 0;
            ref_inv    = '1;
            ref_mln    = 1'b1;
            ref_count  = 0;
            run_cycles = 0;
        end else begin
            if (DUT.u_assert.assert_errors != 0) begin
                $display("A bound assertion on the DUT failed");
                end_in_failure();
            end
            if (word_valid) begin
                if (exp_q.size() == 0) begin
                    $display("word_valid was raised while no word was complete");
                    end_in_failure();
                end
                if (words_checked == 0) check("first strobe time", WORD_CYCLES, run_cycles);
                check(name_q.pop_front(), exp_q.pop_front(), word);
                words_checked++;
            end else if (exp_q.size() != 0) begin
                $display("word_valid did not follow a completed word");
                end_in_failure();
            end
            ref_out = ref_cycle(ref_phase, discretes, ref_inv, ref_mln);
            // The v1 hold and the w2, x1 and y7 terms never reach a z2 sample
            check($sformatf("ml1_2 in phase %0d", ref_phase), ref_out[1], DUT.u_sampler.ml1_2);
            if (ref_phase == 4) begin
                ref_shift = (ref_shift << 1) | sd_word_t'(ref_out[1]);
                ref_count++;
                if (ref_count == WORD_BITS) begin
                    exp_q.push_back(ref_shift);
                    name_q.push_back(cur_test);
                    ref_count = 0;
                end
            end
            ref_mln    = ref_out[0];
            ref_inv    = inverted_inputs(discretes);
            ref_phase  = (ref_phase + 1) % PHASES;
            run_cycles++;
        end
    end

    always @(posedge sim_clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles before all words were seen", cycle_count);
            end_in_failure();
        end
    end

    initial begin
        sd_discretes_t d;
        rst        = 1'b1;
        discretes  = '0;
        lfsr_state = 32'hd770;
        cur_test   = "reset_idle";
        repeat (2) @(posedge sim_clk);
        rst <= 1'b0;
        wait_strobes(2);

        for (int k = 0; k < 9; k++) begin
            cur_test = $sformatf("single_term_%0d", k);
            discretes <= term_inputs(k);
            wait_strobes(2);
        end

        cur_test = "latch_hold";
        discretes <= term_inputs(6);
        wait_strobes(2);
        discretes <= '0;
        wait_strobes(3);

        cur_test = "release";
        d = term_inputs(0);
        d.resmv = 1'b1;
        d.mlav = 1'b1;
        discretes <= d;
        wait_strobes(2);
        d = '0;
        d.resmv = 1'b1;
        d.mlav = 1'b1;
        discretes <= d;
        wait_strobes(2);
        discretes <= '0;
        wait_strobes(1);

        cur_test = "random_soak";
        soak(200);
        repeat (2) @(posedge sim_clk);
        check("words compared", TOTAL_WORDS, words_checked);
        check("assertion failures", 0, DUT.u_assert.assert_errors);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
sd_pkg.sv
sd_gates.sv
sd_phase_gen.sv
sd_sampler_2.sv
sd_word_collector.sv
sd_top.sv
sd_top_assert.sv
tb_sd_top.sv

/* Makefile */
TOP := tb_sd_top

all: run

obj_dir/V$(TOP): src.f *.sv sd_cfg.svh
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
